// File: hdl/axi_pte_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_walk_settings.svh"

module axi_pte_reader (
    input  logic                       clk,
    input  logic                       rst,
    input  mmu_walk_pkg::pte_rd_req_t  pte_rd_req,
    output mmu_walk_pkg::pte_rd_resp_t pte_rd_resp,
    output mmu_walk_pkg::axi_ar_t      axi_ar,
    input  logic                       arready,
    input  mmu_walk_pkg::axi_r_t       axi_r,
    output logic                       rready
);
    import mmu_walk_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,  // arvalid up
        DATA   // rready up
    } state_t;

    state_t      state_q;
    logic        arvalid_q;
    logic        done_q;    // response strobe
    logic [63:0] addr_q;
    logic [63:0] data_q;
    logic        beat;

    always_comb beat = rready & axi_r.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= IDLE;
            arvalid_q <= 1'b0;
            rready    <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= beat;
            case (state_q)
                IDLE: begin
                    if (pte_rd_req.valid) begin
                        arvalid_q <= 1'b1;
                        state_q   <= ADDR;
                    end
                end
                ADDR: begin
                    if (arready) begin
                        arvalid_q <= 1'b0;
                        rready    <= 1'b1;
                        state_q   <= DATA;
                    end
                end
                DATA: begin
                    if (axi_r.valid) begin
                        rready  <= 1'b0; // single beat, len 0
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && pte_rd_req.valid) begin
            addr_q <= pte_rd_req.addr;
        end
        if (beat) begin
            data_q <= axi_r.data;
        end
    end

    always_comb begin
        axi_ar.id    = '0;
        axi_ar.addr  = addr_q;
        axi_ar.len   = 8'd0;
        axi_ar.size  = `AXI_SIZE_8B;
        axi_ar.burst = `AXI_BURST_INCR;
        axi_ar.lock  = 1'b0;
        axi_ar.cache = 4'd0;
        axi_ar.prot  = 3'd0;
        axi_ar.qos   = 4'd0;
        axi_ar.valid = arvalid_q;
    end

    always_comb begin
        pte_rd_resp.valid = done_q;
        pte_rd_resp.data  = data_q;
    end

endmodule

`default_nettype wire

// File: hdl/mmu_walk_pkg.sv
`default_nettype none

`include "mmu_walk_settings.svh"

package mmu_walk_pkg;

    typedef struct packed {
        logic [3:0]           mode;
        logic [15:0]          asid;
        logic [`PPN_BITS-1:0] ppn;   // root page table
    } satp_t;

    typedef struct packed {
        logic                valid; // one-cycle strobe
        logic [`ID_BITS-1:0] id;
        logic [63:0]         vaddr;
        satp_t               satp;
    } walk_req_t;

    typedef struct packed {
        logic                valid;
        logic [`ID_BITS-1:0] id;
        logic [7:0]          perm;  // zero on any fault
        logic [63:0]         paddr; // page aligned
    } walk_resp_t;

    typedef struct packed {
        logic        valid;
        logic [63:0] addr;  // 8-byte aligned
    } pte_rd_req_t;

    typedef struct packed {
        logic        valid;
        logic [63:0] data;
    } pte_rd_resp_t;

    // flag view of a PTE
    typedef struct packed {
        logic [9:0]           rsvd;
        logic [`PPN_BITS-1:0] ppn;
        logic [1:0]           rsw;
        logic [7:0]           flags; // D A G U X W R V
    } pte_flag_t;

    // same word, PPN split into VPN-sized segments
    typedef struct packed {
        logic [9:0]                     rsvd;
        logic [`PPN_BITS-4*`VPN_BITS-1:0] ppn_top;
        logic [3:0][`VPN_BITS-1:0]      seg;   // ppn[0] .. ppn[3]
        logic [9:0]                     low;
    } pte_seg_t;

    typedef union packed {
        pte_flag_t flag;
        pte_seg_t  seg;
    } pte_u;

    typedef struct packed {
        logic [7:0]  id;
        logic [63:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
        logic        lock;
        logic [3:0]  cache;
        logic [2:0]  prot;
        logic [3:0]  qos;
        logic        valid;
    } axi_ar_t;

    typedef struct packed {
        logic [7:0]  id;
        logic [63:0] data;
        logic [1:0]  resp;
        logic        last;
        logic        valid;
    } axi_r_t;

endpackage

`default_nettype wire

// File: hdl/mmu_walk_settings.svh
`ifndef MMU_WALK_SETTINGS_SVH
`define MMU_WALK_SETTINGS_SVH

// request side
`define ID_BITS         8

// Sv39/Sv48/Sv57 paging format
`define VPN_BITS        9
`define PAGE_SHIFT      12
`define PPN_BITS        44

// satp.mode encodings
`define MODE_SV39       4'd8
`define MODE_SV48       4'd9
`define MODE_SV57       4'd10

// AXI read constants
`define AXI_SIZE_8B     3'd3
`define AXI_BURST_INCR  2'd1

`endif

// File: hdl/mmu_walk_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_walk_top (
    input  logic                     clk,
    input  logic                     rst,
    input  mmu_walk_pkg::walk_req_t  i_req,    // instruction side
    input  mmu_walk_pkg::walk_req_t  d_req,    // data side
    output mmu_walk_pkg::walk_resp_t resp,
    output mmu_walk_pkg::axi_ar_t    axi_ar,
    input  logic                     arready,
    input  mmu_walk_pkg::axi_r_t     axi_r,
    output logic                     rready
);
    import mmu_walk_pkg::*;

    walk_req_t    walk_req;    // granted request
    logic         walk_busy;
    pte_rd_req_t  pte_rd_req;
    pte_rd_resp_t pte_rd_resp;

    walk_req_arbiter walk_req_arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .i_req     (i_req),
        .d_req     (d_req),
        .walk_busy (walk_busy),
        .walk_req  (walk_req)
    );

    page_walker page_walker_i (
        .clk         (clk),
        .rst         (rst),
        .walk_req    (walk_req),
        .walk_busy   (walk_busy),
        .pte_rd_req  (pte_rd_req),
        .pte_rd_resp (pte_rd_resp),
        .resp        (resp)
    );

    // PTE fetches go straight to memory
    axi_pte_reader axi_pte_reader_i (
        .clk         (clk),
        .rst         (rst),
        .pte_rd_req  (pte_rd_req),
        .pte_rd_resp (pte_rd_resp),
        .axi_ar      (axi_ar),
        .arready     (arready),
        .axi_r       (axi_r),
        .rready      (rready)
    );

endmodule

`default_nettype wire

// File: hdl/page_walker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_walk_settings.svh"

module page_walker (
    input  logic                       clk,
    input  logic                       rst,
    input  mmu_walk_pkg::walk_req_t    walk_req,
    output logic                       walk_busy,
    output mmu_walk_pkg::pte_rd_req_t  pte_rd_req,
    input  mmu_walk_pkg::pte_rd_resp_t pte_rd_resp,
    output mmu_walk_pkg::walk_resp_t   resp
);
    import mmu_walk_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        READ,  // read strobe for the current level
        WAIT,  // PTE outstanding
        NEXT,  // spacer before the next level
        DONE   // response strobe
    } state_t;

    state_t                         state_q;
    logic   [`ID_BITS-1:0]          id_q;
    logic   [4:0][`VPN_BITS-1:0]    vpn_q;
    logic   [`PPN_BITS-1:0]         ppn_q;
    logic   [2:0]                   level_q;
    logic   [7:0]                   perm_q;
    logic                           accept;
    logic                           mode_ok;
    logic   [2:0]                   start_level;
    pte_u                           pte;
    pte_u                           leaf_pte;   // pte with superpage segments filled
    logic                           pte_v;
    logic                           is_leaf;
    logic                           misaligned;
    logic                           descend;
    logic                           pte_seen;

    always_comb accept = (state_q == IDLE) & walk_req.valid;

    // levels below the root, from satp.mode
    always_comb begin
        mode_ok = 1'b1;
        case (walk_req.satp.mode)
            `MODE_SV39: start_level = 3'd2;
            `MODE_SV48: start_level = 3'd3;
            `MODE_SV57: start_level = 3'd4;
            default: begin
                start_level = 3'd0;
                mode_ok     = 1'b0; // unsupported mode, fault at once
            end
        endcase
    end

    always_comb begin
        pte        = pte_rd_resp.data;
        leaf_pte   = pte;
        misaligned = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (i < level_q) begin
                if (pte.seg.seg[i] != '0) begin
                    misaligned = 1'b1;
                end
                leaf_pte.seg.seg[i] = vpn_q[i];
            end
        end
        pte_v   = pte.flag.flags[0];
        is_leaf = pte.flag.flags[1] | pte.flag.flags[3]; // R or X
        descend = pte_v & ~is_leaf & (level_q != 3'd0);
    end

    always_comb pte_seen = (state_q == WAIT) & pte_rd_resp.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (walk_req.valid) begin
                        state_q <= mode_ok ? READ : DONE;
                    end
                end
                READ: state_q <= WAIT;
                WAIT: begin
                    if (pte_rd_resp.valid) begin
                        state_q <= descend ? NEXT : DONE;
                    end
                end
                NEXT: state_q <= READ;
                DONE: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_q    <= walk_req.id;
            vpn_q   <= walk_req.vaddr[`PAGE_SHIFT +: 5 * `VPN_BITS];
            ppn_q   <= walk_req.satp.ppn;
            level_q <= start_level;
            perm_q  <= 8'd0;
        end else if (pte_seen) begin
            ppn_q  <= is_leaf ? leaf_pte.flag.ppn : pte.flag.ppn;
            // V clear, misaligned superpage or pointer at level 0 all give 0
            perm_q <= (pte_v & is_leaf & ~misaligned) ? pte.flag.flags : 8'd0;
            if (descend) begin
                level_q <= level_q - 3'd1;
            end
        end
    end

    always_comb walk_busy = (state_q != IDLE);

    always_comb begin
        pte_rd_req.valid = (state_q == READ);
        pte_rd_req.addr  = 64'({ppn_q, vpn_q[level_q], 3'b000}); // 8 bytes per PTE
    end

    always_comb begin
        resp.valid = (state_q == DONE);
        resp.id    = id_q;
        resp.perm  = perm_q;
        resp.paddr = 64'(ppn_q) << `PAGE_SHIFT;
    end

endmodule

`default_nettype wire

// File: hdl/walk_req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module walk_req_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  mmu_walk_pkg::walk_req_t i_req,
    input  mmu_walk_pkg::walk_req_t d_req,
    input  logic                    walk_busy,
    output mmu_walk_pkg::walk_req_t walk_req
);
    import mmu_walk_pkg::*;

    // index 0 is the data side, index 1 the instruction side
    walk_req_t       side_req  [2];
    walk_req_t       payload_q [2]; // held request
    walk_req_t       cand      [2]; // buffered entry, else live strobe
    logic      [1:0] held_q;
    logic      [1:0] grant;

    always_comb begin
        side_req[0] = d_req;
        side_req[1] = i_req;
        for (int s = 0; s < 2; s++) begin
            cand[s] = held_q[s] ? payload_q[s] : side_req[s];
        end
    end

    // data side has priority
    always_comb begin
        grant[0] = ~walk_busy & cand[0].valid;
        grant[1] = ~walk_busy & ~cand[0].valid & cand[1].valid;
    end

    always_comb begin
        walk_req       = cand[0].valid ? cand[0] : cand[1];
        walk_req.valid = |grant;
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            if (rst) begin
                held_q[s] <= 1'b0;
            end else begin
                held_q[s] <= cand[s].valid & ~grant[s]; // drops on handover
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            payload_q[s] <= cand[s];
        end
    end

endmodule

`default_nettype wire

// File: testbench/mmu_walk_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_walk_assertions (
    input logic                     clk,
    input logic                     rst,
    input mmu_walk_pkg::axi_ar_t    axi_ar,
    input logic                     arready,
    input mmu_walk_pkg::walk_resp_t resp
);

    // one aligned 8-byte beat per PTE
    ar_single_beat: assert property (@(posedge clk) disable iff (rst)
        axi_ar.valid |-> (axi_ar.len == 8'd0) && (axi_ar.addr[2:0] == 3'b000))
        else $error("AR request is not a single aligned 8-byte beat");

    ar_held: assert property (@(posedge clk) disable iff (rst)
        axi_ar.valid && !arready |=> axi_ar.valid)
        else $error("arvalid dropped before arready");

    resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
        resp.valid |=> !resp.valid)
        else $error("resp valid lasted two cycles");

endmodule

bind mmu_walk_top mmu_walk_assertions mmu_walk_assertions_i (
    .clk     (clk),
    .rst     (rst),
    .axi_ar  (axi_ar),
    .arready (arready),
    .resp    (resp)
);

`default_nettype wire

// File: testbench/tb_axi_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
    input  logic                  clk,
    input  logic                  rst,
    input  mmu_walk_pkg::axi_ar_t axi_ar,
    output logic                  arready,
    output mmu_walk_pkg::axi_r_t  axi_r,
    input  logic                  rready
);
    import mmu_walk_pkg::*;

    localparam int MEM_WORDS = 32768; // 64 pages of 512 PTEs

    typedef enum logic [2:0] {
        IDLE,
        AR_WAIT,  // random delay before arready
        AR_HS,    // arready up for one cycle
        R_WAIT,   // random delay before rvalid
        R_BEAT    // rvalid held until rready
    } state_t;

    logic   [63:0] mem [MEM_WORDS]; // written by the testbench at time zero
    state_t        state_q;
    logic   [31:0] rng_q;
    logic   [31:0] rng_next;
    logic   [1:0]  wait_q;
    logic   [63:0] addr_q;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always_comb rng_next = next_random(rng_q);

    initial begin
        arready = 1'b0;
        axi_r   = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            rng_q   <= 32'd85;
            wait_q  <= 2'd0;
            addr_q  <= '0;
            arready <= 1'b0;
            axi_r   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (axi_ar.valid) begin
                        rng_q   <= rng_next;
                        wait_q  <= rng_next[1:0]; // 0 to 3 cycles
                        state_q <= AR_WAIT;
                    end
                end
                AR_WAIT: begin
                    if (wait_q != 2'd0) begin
                        wait_q <= wait_q - 2'd1;
                    end else begin
                        arready <= 1'b1;
                        state_q <= AR_HS;
                    end
                end
                AR_HS: begin
                    arready <= 1'b0;
                    addr_q  <= axi_ar.addr;
                    rng_q   <= rng_next;
                    wait_q  <= rng_next[1:0];
                    state_q <= R_WAIT;
                end
                R_WAIT: begin
                    if (wait_q != 2'd0) begin
                        wait_q <= wait_q - 2'd1;
                    end else begin
                        axi_r.valid <= 1'b1;
                        axi_r.last  <= 1'b1;
                        axi_r.resp  <= 2'b00;
                        axi_r.id    <= '0;
                        axi_r.data  <= mem[addr_q[17:3]];
                        state_q     <= R_BEAT;
                    end
                end
                R_BEAT: begin
                    if (rready) begin
                        axi_r.valid <= 1'b0;
                        axi_r.last  <= 1'b0;
                        state_q     <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_mmu_walk.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mmu_walk;
    import mmu_walk_pkg::*;

    localparam int         N_TESTS         = 17;
    localparam int         WATCHDOG_CYCLES = 200;  // per table entry
    localparam logic [1:0] ALONE           = 2'd0; // after the previous group is done
    localparam logic [1:0] SAME            = 2'd1; // same cycle as the entry before
    localparam logic [1:0] NEXT            = 2'd2; // one cycle after the entry before
    localparam logic       ISIDE           = 1'b0;
    localparam logic       DSIDE           = 1'b1;
    localparam logic [7:0] PTR             = 8'h01; // V only, points to next level

    typedef struct packed {
        logic        data_side;
        logic [1:0]  issue;
        logic [1:0]  order;   // response position within its group
        logic [2:0]  reads;   // AR handshakes of this walk
        logic [7:0]  id;
        logic [63:0] vaddr;
        satp_t       satp;
        logic [7:0]  perm;
        logic [63:0] paddr;
    } test_entry_t;

    logic        clk;
    logic        rst;
    walk_req_t   i_req;
    walk_req_t   d_req;
    walk_resp_t  resp;
    axi_ar_t     axi_ar;
    logic        arready;
    axi_r_t      axi_r;
    logic        rready;
    test_entry_t tests [N_TESTS];
    int          n_added;
    walk_resp_t  resp_q [$];
    int          ar_count;

    mmu_walk_top mmu_walk_top_i (
        .clk     (clk),
        .rst     (rst),
        .i_req   (i_req),
        .d_req   (d_req),
        .resp    (resp),
        .axi_ar  (axi_ar),
        .arready (arready),
        .axi_r   (axi_r),
        .rready  (rready)
    );

    tb_axi_mem axi_mem_i (
        .clk     (clk),
        .rst     (rst),
        .axi_ar  (axi_ar),
        .arready (arready),
        .axi_r   (axi_r),
        .rready  (rready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk; // 4 ns period

    always @(negedge clk) begin
        if (!rst && resp.valid) begin
            resp_q.push_back(resp);
        end
        if (!rst && axi_ar.valid) begin
            check_ar_fields();
        end
        if (!rst && axi_ar.valid && arready) begin
            ar_count++;
        end
    end

    function automatic logic [63:0] pte_word(input logic [43:0] ppn, input logic [7:0] flags);
        return {10'd0, ppn, 2'b00, flags};
    endfunction

    function automatic logic [63:0] make_va(input logic [8:0] v4, input logic [8:0] v3,
                                            input logic [8:0] v2, input logic [8:0] v1,
                                            input logic [8:0] v0);
        return {7'd0, v4, v3, v2, v1, v0, 12'h5a8}; // offset must not reach paddr
    endfunction

    function automatic satp_t make_satp(input logic [3:0] mode, input logic [43:0] root);
        return {mode, 16'h0000, root};
    endfunction

    function automatic logic [63:0] page_addr(input logic [43:0] ppn);
        return 64'(ppn) << 12;
    endfunction

    task automatic place_pte(input logic [43:0] table_ppn, input logic [8:0] index,
                             input logic [63:0] word);
        axi_mem_i.mem[{table_ppn[5:0], index}] = word;
    endtask

    task automatic add_entry(input logic data_side, input logic [1:0] issue,
                             input logic [1:0] order, input logic [2:0] reads,
                             input logic [7:0] id, input logic [63:0] vaddr, input satp_t satp,
                             input logic [7:0] perm, input logic [63:0] paddr);
        tests[n_added] = {data_side, issue, order, reads, id, vaddr, satp, perm, paddr};
        n_added++;
    endtask

    task automatic build_table();
        logic [63:0] va_a;
        logic [63:0] va_b;
        logic [63:0] va_c;
        logic [63:0] va_d;
        logic [63:0] va_e;
        logic [63:0] va_f;
        logic [63:0] va_g;
        satp_t       s39;
        satp_t       s48;
        satp_t       s57;
        satp_t       s_sp;
        satp_t       s_m1;
        satp_t       s_m0;
        for (int w = 0; w < 32768; w++) begin
            axi_mem_i.mem[w] = 64'(w) << 3; // byte address, V clear
        end
        va_a = make_va(9'd0, 9'd0, 9'd3, 9'd5, 9'd7);
        va_b = make_va(9'd0, 9'd1, 9'd2, 9'd3, 9'd4);
        va_c = make_va(9'd9, 9'd8, 9'd7, 9'd6, 9'd5);
        va_d = make_va(9'd0, 9'd0, 9'd1, 9'd2, 9'h155);
        va_e = make_va(9'd0, 9'd0, 9'd3, 9'd6, 9'h010);
        va_f = make_va(9'd0, 9'd0, 9'd3, 9'd8, 9'h0aa);
        va_g = make_va(9'd0, 9'd0, 9'd3, 9'd5, 9'd9);
        s39  = make_satp(4'd8, 44'd1);
        s48  = make_satp(4'd9, 44'd4);
        s57  = make_satp(4'd10, 44'd8);
        s_sp = make_satp(4'd8, 44'd13);
        s_m1 = make_satp(4'd1, 44'd1);
        s_m0 = make_satp(4'd0, 44'd4);
        // Sv39 from root 1
        place_pte(44'd1, 9'd3, pte_word(44'd2, PTR));
        place_pte(44'd2, 9'd5, pte_word(44'd3, PTR));
        place_pte(44'd3, 9'd7, pte_word(44'h123, 8'hcf));
        place_pte(44'd2, 9'd6, pte_word(44'h77, 8'h00));           // V clear
        place_pte(44'd2, 9'd8, pte_word({35'h2a, 9'h011}, 8'hcf)); // ppn[0] nonzero
        place_pte(44'd3, 9'd9, pte_word(44'h99, PTR));             // pointer at level 0
        // Sv48 from root 4
        place_pte(44'd4, 9'd1, pte_word(44'd5, PTR));
        place_pte(44'd5, 9'd2, pte_word(44'd6, PTR));
        place_pte(44'd6, 9'd3, pte_word(44'd7, PTR));
        place_pte(44'd7, 9'd4, pte_word(44'habcde, 8'h4b));
        // Sv57 from root 8
        place_pte(44'd8, 9'd9, pte_word(44'd9, PTR));
        place_pte(44'd9, 9'd8, pte_word(44'd10, PTR));
        place_pte(44'd10, 9'd7, pte_word(44'd11, PTR));
        place_pte(44'd11, 9'd6, pte_word(44'd12, PTR));
        place_pte(44'd12, 9'd5, pte_word(44'h1234_5678_9ab, 8'hdb));
        // 2 MiB leaf at level 1 under root 13
        place_pte(44'd13, 9'd1, pte_word(44'd14, PTR));
        place_pte(44'd14, 9'd2, pte_word({35'h5a5, 9'h000}, 8'hc7));
        add_entry(ISIDE, ALONE, 2'd0, 3'd3, 8'h01, va_a, s39, 8'hcf, page_addr(44'h123));
        add_entry(DSIDE, ALONE, 2'd0, 3'd4, 8'h02, va_b, s48, 8'h4b, page_addr(44'habcde));
        add_entry(ISIDE, ALONE, 2'd0, 3'd5, 8'h03, va_c, s57, 8'hdb, page_addr(44'h1234_5678_9ab));
        add_entry(DSIDE, ALONE, 2'd0, 3'd2, 8'h04, va_d, s_sp, 8'hc7, page_addr({35'h5a5, 9'h155}));
        // faults, bad modes end on the root PPN
        add_entry(ISIDE, ALONE, 2'd0, 3'd0, 8'h05, va_a, s_m1, 8'h00, page_addr(44'd1));
        add_entry(DSIDE, ALONE, 2'd0, 3'd0, 8'h06, va_b, s_m0, 8'h00, page_addr(44'd4));
        add_entry(ISIDE, ALONE, 2'd0, 3'd2, 8'h07, va_e, s39, 8'h00, page_addr(44'h77));
        add_entry(DSIDE, ALONE, 2'd0, 3'd2, 8'h08, va_f, s39, 8'h00, page_addr({35'h2a, 9'h0aa}));
        add_entry(ISIDE, ALONE, 2'd0, 3'd3, 8'h09, va_g, s39, 8'h00, page_addr(44'h99));
        // both sides in one cycle, data side served first
        add_entry(ISIDE, ALONE, 2'd1, 3'd3, 8'h21, va_a, s39, 8'hcf, page_addr(44'h123));
        add_entry(DSIDE, SAME, 2'd0, 3'd4, 8'h22, va_b, s48, 8'h4b, page_addr(44'habcde));
        // back to back, alternating sides
        add_entry(ISIDE, ALONE, 2'd0, 3'd5, 8'h31, va_c, s57, 8'hdb, page_addr(44'h1234_5678_9ab));
        add_entry(DSIDE, NEXT, 2'd1, 3'd2, 8'h32, va_d, s_sp, 8'hc7, page_addr({35'h5a5, 9'h155}));
        add_entry(DSIDE, ALONE, 2'd0, 3'd2, 8'h41, va_f, s39, 8'h00, page_addr({35'h2a, 9'h0aa}));
        add_entry(ISIDE, NEXT, 2'd1, 3'd3, 8'h42, va_a, s39, 8'hcf, page_addr(44'h123));
        add_entry(ISIDE, ALONE, 2'd0, 3'd2, 8'h51, va_d, s_sp, 8'hc7, page_addr({35'h5a5, 9'h155}));
        add_entry(DSIDE, NEXT, 2'd1, 3'd3, 8'h52, va_g, s39, 8'h00, page_addr(44'h99));
    endtask

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // fixed AR fields of a single 8-byte read
    task automatic check_ar_fields();
        compare_value("axi_ar.id", 64'd0, 64'(axi_ar.id));
        compare_value("axi_ar.size", 64'd3, 64'(axi_ar.size));   // 8 bytes
        compare_value("axi_ar.burst", 64'd1, 64'(axi_ar.burst)); // INCR
        compare_value("axi_ar.lock", 64'd0, 64'(axi_ar.lock));
        compare_value("axi_ar.cache", 64'd0, 64'(axi_ar.cache));
        compare_value("axi_ar.prot", 64'd0, 64'(axi_ar.prot));
        compare_value("axi_ar.qos", 64'd0, 64'(axi_ar.qos));
        compare_value("rready", 64'd0, 64'(rready)); // no data phase before the address handshake
    endtask

    task automatic drive_request(input test_entry_t t);
        walk_req_t req;
        req = {1'b1, t.id, t.vaddr, t.satp};
        if (t.data_side) begin
            d_req <= req;
        end else begin
            i_req <= req;
        end
    endtask

    initial begin
        repeat (N_TESTS * WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: no response after %0d cycles per table entry", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int         idx;
        int         grp_end;
        int         ar_start;
        int         reads_sum;
        int         e;
        logic       found;
        walk_resp_t r;
        rst      = 1'b1;
        i_req    = '0;
        d_req    = '0;
        ar_count = 0;
        n_added  = 0;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        idx = 0;
        while (idx < N_TESTS) begin
            grp_end = idx + 1;
            while (grp_end < N_TESTS && tests[grp_end].issue != ALONE) begin
                grp_end++;
            end
            ar_start  = ar_count;
            reads_sum = 0;
            for (int k = idx; k < grp_end; k++) begin
                if (k == idx || tests[k].issue == NEXT) begin
                    @(posedge clk);
                    i_req.valid <= 1'b0;
                    d_req.valid <= 1'b0;
                end
                drive_request(tests[k]);
                reads_sum += tests[k].reads;
            end
            @(posedge clk);
            i_req.valid <= 1'b0;
            d_req.valid <= 1'b0;
            while (resp_q.size() < grp_end - idx) begin
                @(negedge clk);
            end
            compare_value("AR handshakes", 64'(reads_sum), 64'(ar_count - ar_start));
            for (int j = 0; j < grp_end - idx; j++) begin
                r     = resp_q[j];
                found = 1'b0;
                e     = idx;
                for (int k = idx; k < grp_end; k++) begin
                    if (tests[k].id == r.id) begin
                        found = 1'b1;
                        e     = k;
                    end
                end
                compare_value("resp.id known", 64'd1, 64'(found));
                compare_value("response order", 64'(tests[e].order), 64'(j));
                compare_value("resp.perm", 64'(tests[e].perm), 64'(r.perm));
                compare_value("resp.paddr", tests[e].paddr, r.paddr);
            end
            resp_q.delete();
            idx = grp_end;
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hdl
hdl/mmu_walk_pkg.sv
hdl/walk_req_arbiter.sv
hdl/page_walker.sv
hdl/axi_pte_reader.sv
hdl/mmu_walk_top.sv
testbench/tb_axi_mem.sv
testbench/mmu_walk_assertions.sv
testbench/tb_mmu_walk.sv
